// ==== tests/cpu_patterns.hex ====
// Program words from address 0, four per line
// At @40 the final PC, the store count, then one store per line: dmem_addr byteenable wdata
@00
20000513 06400093 FF900113 402081B3  // Base 0x200, x1 = 100, x2 = -7, SUB
00352023 40115213 00452223 0020B2B3  // SRAI of a negative value, SLTU
00552423 12345337 67834313 006506A3  // LUI, XORI, SB at offset 13
00651923 10000593 00258603 00C52A23  // SH at offset 18, LB from 0x102
0025C683 00D52C23 00259703 00E52E23  // LBU, LH
0025D783 02F52023 00108463 10252023  // LHU, BEQ taken over a skipped store
00109463 02152223 0020C463 02152423  // BNE and BLT fall through
0020D463 10252023 0020E463 10252023  // BGE and BLTU taken
0020F463 02152623 008008EF 10252023  // BGEU falls through, JAL over a skipped store
03152823 00000917 00D909E7 10252023  // AUIPC, JALR with an odd offset
03352A23 00000073                    // Store of the JALR link, ECALL
@40
000000A4  // Final PC at the ECALL
0000000E  // Number of stores
00000200 0000000F 0000006B
00000204 0000000F FFFFFFFC
00000208 0000000F 00000001
0000020C 00000002 00007800
00000210 0000000C 56780000
00000214 0000000F FFFFFFF0
00000218 0000000F 000000F0
0000021C 0000000F FFFF80F0
00000220 0000000F 000080F0
00000224 0000000F 00000064
00000228 0000000F 00000064
0000022C 0000000F 00000064
00000230 0000000F 0000008C
00000234 0000000F 0000009C

// ==== vlog.f ====
hw/cpu_pkg.sv
hw/rv_isa_pkg.sv
hw/ctrl_if.sv
hw/decoder.sv
hw/control_unit.sv
hw/alu.sv
hw/register_file.sv
hw/memory_unit.sv
hw/cpu.sv
tests/cpu_props.sv
tests/cpu_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = cpu_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
PASS_MSG  = Done: no errors

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/cpu_tb.sv ====
module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 256;
  localparam int PAT_WORDS  = 128;
  localparam int REC_BASE   = 64;    // Final PC, store count, then the store triples
  localparam int MAX_WAIT   = 3;
  localparam int MAX_CYCLES = 2000;  // Forty program words at worst-case latency, rounded up

  logic        clk;
  logic        rst;
  logic        imem_read;
  logic [31:0] imem_addr;
  logic        imem_wait;
  logic [31:0] imem_rdata;
  logic        imem_rdata_valid;
  logic        dmem_read;
  logic        dmem_write;
  logic [31:0] dmem_addr;
  logic [3:0]  dmem_byteenable;
  logic [31:0] dmem_wdata;
  logic        dmem_wait;
  logic [31:0] dmem_rdata;
  logic        dmem_rdata_valid;
  logic        halted;
  logic [31:0] debug_pc;
  logic [31:0] debug_instruction;

  logic [31:0] pat  [0:PAT_WORDS-1];
  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];

  int unsigned cycles, tests, errors, store_count;
  int unsigned i_lat, i_cnt, i_draw, d_lat, d_cnt, d_draw;
  logic        i_pend, d_pend;
  logic [5:0]  i_idx;
  logic [7:0]  d_idx;
  logic        fetch_seen, early_strobe, quiet_after_halt;

  cpu UUT (
    .clk(clk), .rst(rst),
    .imem_read(imem_read), .imem_addr(imem_addr), .imem_wait(imem_wait),
    .imem_rdata(imem_rdata), .imem_rdata_valid(imem_rdata_valid),
    .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
    .dmem_byteenable(dmem_byteenable), .dmem_wdata(dmem_wdata), .dmem_wait(dmem_wait),
    .dmem_rdata(dmem_rdata), .dmem_rdata_valid(dmem_rdata_valid),
    .halted(halted), .debug_pc(debug_pc), .debug_instruction(debug_instruction)
  );

  always #5 clk = ~clk;

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    tests++;
    assert (actual === expected) $display("Pass %s", name);
    else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic expect_true(input string name, input logic cond, input string what);
    tests++;
    assert (cond) $display("Pass %s", name);
    else begin
      errors++;
      $display("Error in %s: %s", name, what);
    end
  endtask

  // Each accepted write must be the next record, a skipped instruction shows up here
  task automatic match_store(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
    int    base;
    string name;
    base = REC_BASE + 2 + 3 * int'(store_count);
    name = $sformatf("store_%0d", store_count + 1);
    if (store_count < pat[REC_BASE + 1]) begin
      tests++;
      assert (addr === pat[base] && be === pat[base + 1][3:0] && data === pat[base + 2])
        $display("Pass %s", name);
      else begin
        errors++;
        $display("Fail %s: expected %h/%h/%h, actual %h/%h/%h", name, pat[base],
                 pat[base + 1][3:0], pat[base + 2], addr, be, data);
      end
    end else begin
      expect_true(name, 1'b0, $sformatf("unexpected store to %h after the last record", addr));
    end
    store_count++;
  endtask

  // ====================================================================
  // Bus models with random wait and read latency
  // ====================================================================

  always @(posedge clk) begin
    imem_rdata_valid <= 1'b0;
    if (i_pend) begin
      if (i_lat == 0) begin
        imem_rdata_valid <= 1'b1;
        imem_rdata       <= imem[i_idx];
        i_pend           <= 1'b0;
      end else begin
        i_lat <= i_lat - 1;
      end
    end
    if (imem_read && !imem_wait) begin
      i_draw = $urandom % (MAX_WAIT + 1);
      i_pend    <= 1'b1;
      i_idx     <= imem_addr[7:2];
      i_lat     <= $urandom % (MAX_WAIT + 1);
      i_cnt     <= i_draw;
      imem_wait <= (i_draw != 0);  // Wait states for the next request
    end else if (imem_read) begin
      i_cnt     <= i_cnt - 1;
      imem_wait <= (i_cnt > 1);
    end
  end

  always @(posedge clk) begin
    dmem_rdata_valid <= 1'b0;
    if (d_pend) begin
      if (d_lat == 0) begin
        dmem_rdata_valid <= 1'b1;
        dmem_rdata       <= dmem[d_idx];
        d_pend           <= 1'b0;
      end else begin
        d_lat <= d_lat - 1;
      end
    end
    if ((dmem_read || dmem_write) && !dmem_wait) begin
      d_draw = $urandom % (MAX_WAIT + 1);
      d_cnt     <= d_draw;
      dmem_wait <= (d_draw != 0);
      if (dmem_read) begin
        d_pend <= 1'b1;
        d_idx  <= dmem_addr[9:2];
        d_lat  <= $urandom % (MAX_WAIT + 1);
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (dmem_byteenable[b]) dmem[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
        end
        match_store(dmem_addr, dmem_byteenable, dmem_wdata);
      end
    end else if (dmem_read || dmem_write) begin
      d_cnt     <= d_cnt - 1;
      dmem_wait <= (d_cnt > 1);
    end
  end

  // ====================================================================
  // Reset and halt monitors, watchdog
  // ====================================================================

  always @(posedge clk) begin
    if (rst && !fetch_seen) begin
      if (dmem_read || dmem_write) early_strobe <= 1'b1;
      if (imem_read) begin
        fetch_seen <= 1'b1;
        compare_word("reset_first_fetch", 32'h0000_0000, imem_addr);
        expect_true("reset_data_bus_idle", !early_strobe && !dmem_read && !dmem_write,
                    "a data strobe was active before the first fetch");
      end
    end
    if (halted && (imem_read || dmem_read || dmem_write)) quiet_after_halt <= 1'b0;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: halted did not rise within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    void'($urandom(90401));
    clk = 1'b0;
    rst = 1'b0;
    imem_wait = 1'b0;
    imem_rdata = '0;
    imem_rdata_valid = 1'b0;
    dmem_wait = 1'b0;
    dmem_rdata = '0;
    dmem_rdata_valid = 1'b0;
    i_pend = 1'b0;
    d_pend = 1'b0;
    i_lat = 0;
    i_cnt = 0;
    d_lat = 0;
    d_cnt = 0;
    cycles = 0;
    tests = 0;
    errors = 0;
    store_count = 0;
    fetch_seen = 1'b0;
    early_strobe = 1'b0;
    quiet_after_halt = 1'b1;
    for (int k = 0; k < PAT_WORDS; k++) pat[k] = '0;
    $readmemh("tests/cpu_patterns.hex", pat);
    for (int k = 0; k < IMEM_WORDS; k++) imem[k] = pat[k];
    for (int k = 0; k < DMEM_WORDS; k++) dmem[k] = 32'h80F0_0000 | k;  // Low byte is the index

    repeat (5) @(posedge clk);
    rst <= 1'b1;
    while (!halted) @(posedge clk);
    compare_word("halt_pc", pat[REC_BASE], debug_pc);
    compare_word("halt_instruction", 32'h0000_0073, debug_instruction);  // ECALL encoding
    repeat (8) @(posedge clk);
    expect_true("bus_idle_after_halt", quiet_after_halt, "a bus strobe was active after halt");
    compare_word("store_count", pat[REC_BASE + 1], store_count);
    $display("Tests: %0d, passed: %0d, failed: %0d", tests, tests - errors, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tests/cpu_props.sv ====
module cpu_props (
  input logic        clk,
  input logic        rst,
  input logic        imem_read,
  input logic [31:0] imem_addr,
  input logic        imem_wait,
  input logic        dmem_read,
  input logic        dmem_write,
  input logic [31:0] dmem_addr,
  input logic [3:0]  dmem_byteenable,
  input logic [31:0] dmem_wdata,
  input logic        dmem_wait,
  input logic        halted
);
  timeunit 1ns;
  timeprecision 100ps;

  // ====================================================================
  // Bus protocol and reset
  // ====================================================================

  reset_idle: assert property (@(posedge clk) !rst |-> !imem_read && !dmem_read && !dmem_write)
    else $error("Bus strobe active while reset is asserted");

  read_write_exclusive: assert property (@(posedge clk) disable iff (!rst)
    !(dmem_read && dmem_write))
    else $error("Data read and write strobes active together");

  imem_hold: assert property (@(posedge clk) disable iff (!rst)
    imem_read && imem_wait |=> imem_read && $stable(imem_addr))
    else $error("Instruction request changed under wait");

  dmem_hold: assert property (@(posedge clk) disable iff (!rst)
    (dmem_read || dmem_write) && dmem_wait |=>
      $stable({dmem_read, dmem_write, dmem_addr, dmem_byteenable, dmem_wdata}))
    else $error("Data request changed under wait");

  halt_sticky: assert property (@(posedge clk) disable iff (!rst) halted |=> halted)
    else $error("Halted dropped after rising");

endmodule

bind cpu cpu_props u_props (
  .clk(clk), .rst(rst), .imem_read(imem_read), .imem_addr(imem_addr), .imem_wait(imem_wait),
  .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
  .dmem_byteenable(dmem_byteenable), .dmem_wdata(dmem_wdata), .dmem_wait(dmem_wait),
  .halted(halted)
);

// ==== hw/cpu.sv ====
module cpu (
  input  logic           clk,
  input  logic           rst,
  output logic           imem_read,
  output cpu_pkg::word_t imem_addr,
  input  logic           imem_wait,
  input  cpu_pkg::word_t imem_rdata,
  input  logic           imem_rdata_valid,
  output logic           dmem_read,
  output logic           dmem_write,
  output cpu_pkg::word_t dmem_addr,
  output logic [3:0]     dmem_byteenable,
  output cpu_pkg::word_t dmem_wdata,
  input  logic           dmem_wait,
  input  cpu_pkg::word_t dmem_rdata,
  input  logic           dmem_rdata_valid,
  output logic           halted,
  output cpu_pkg::word_t debug_pc,
  output cpu_pkg::word_t debug_instruction
);
  import cpu_pkg::*;
  import rv_isa_pkg::*;

  word_t      pc, ir, pc_plus4, branch_target;
  word_t      imm, rs1_data, rs2_data, alu_a, alu_b, alu_result, load_data, rd_data;
  opcode_e    opcode;
  logic [4:0] rd, rs1, rs2;
  logic [2:0] f3;
  logic       f7_bit5, alu_zero, mem_done, branch_taken;

  ctrl_if ctl ();

  decoder u_decoder (.ir(ir), .opcode(opcode), .rd(rd), .rs1(rs1), .rs2(rs2), .f3(f3),
                     .f7_bit5(f7_bit5), .imm(imm));

  control_unit u_control (.clk(clk), .rst(rst), .opcode(opcode), .f3(f3), .f7_bit5(f7_bit5),
                          .imem_wait(imem_wait), .imem_rdata_valid(imem_rdata_valid),
                          .mem_done(mem_done), .ctl(ctl), .imem_read(imem_read),
                          .halted(halted));

  register_file u_regs (.clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .we(ctl.rd_write),
                        .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data));

  alu u_alu (.a(alu_a), .b(alu_b), .mode(ctl.alu_mode), .result(alu_result),
             .zero(alu_zero));

  memory_unit u_mem (.clk(clk), .rst(rst), .ctl(ctl), .f3(f3), .addr(alu_result),
                     .store_data(rs2_data), .load_data(load_data), .mem_done(mem_done),
                     .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
                     .dmem_byteenable(dmem_byteenable), .dmem_wdata(dmem_wdata),
                     .dmem_wait(dmem_wait), .dmem_rdata(dmem_rdata),
                     .dmem_rdata_valid(dmem_rdata_valid));

  // ======================================================================
  // Operand and writeback muxes
  // ======================================================================

  assign alu_a         = (ctl.alu_a_sel == A_PC) ? pc : rs1_data;
  assign alu_b         = (ctl.alu_b_sel == B_IMM) ? imm : rs2_data;
  assign pc_plus4      = pc + INSTR_BYTES;
  assign branch_target = pc + imm;  // Own adder, the ALU is busy comparing

  always_comb begin
    case (ctl.wb_sel)
      WB_ALU:  rd_data = alu_result;
      WB_MEM:  rd_data = load_data;
      WB_LINK: rd_data = pc_plus4;
      default: rd_data = '0;
    endcase
  end

  // SUB, SLT or SLTU leaves a zero or non-zero result for each condition
  always_comb begin
    case (f3)
      F3_BEQ, F3_BGE, F3_BGEU: branch_taken = alu_zero;
      F3_BNE, F3_BLT, F3_BLTU: branch_taken = !alu_zero;
      default:                 branch_taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= RESET_PC;
      ir <= '0;
    end else begin
      if (ctl.ir_load) ir <= imem_rdata;
      if (ctl.pc_load_alu) begin
        if (opcode == OPC_BRANCH) pc <= branch_taken ? branch_target : pc_plus4;
        else pc <= {alu_result[31:1], 1'b0};  // JALR drops bit 0
      end else if (ctl.pc_advance) begin
        pc <= pc_plus4;
      end
    end
  end

  assign imem_addr         = pc;
  assign debug_pc          = pc;
  assign debug_instruction = ir;

endmodule

// ==== hw/memory_unit.sv ====
module memory_unit (
  input  logic           clk,
  input  logic           rst,
  ctrl_if.dp             ctl,
  input  logic [2:0]     f3,
  input  cpu_pkg::word_t addr,
  input  cpu_pkg::word_t store_data,
  output cpu_pkg::word_t load_data,
  output logic           mem_done,
  output logic           dmem_read,
  output logic           dmem_write,
  output cpu_pkg::word_t dmem_addr,
  output logic [3:0]     dmem_byteenable,
  output cpu_pkg::word_t dmem_wdata,
  input  logic           dmem_wait,
  input  cpu_pkg::word_t dmem_rdata,
  input  logic           dmem_rdata_valid
);
  import cpu_pkg::*;
  import rv_isa_pkg::*;

  logic [2:0] size;
  logic [4:0] lane_shift;  // Bit offset of the addressed byte
  logic       read_sent;
  word_t      rdata_lane;

  assign size       = {1'b0, f3[1:0]};
  assign lane_shift = {addr[1:0], 3'b000};
  assign dmem_addr  = {addr[31:2], 2'b00};

  // ======================================================================
  // Request side
  // ======================================================================

  always_comb begin
    case (size)
      MEM_BYTE: begin
        dmem_byteenable = 4'b0001 << addr[1:0];
        dmem_wdata      = {24'b0, store_data[7:0]} << lane_shift;
      end
      MEM_HALF: begin
        dmem_byteenable = 4'b0011 << {addr[1], 1'b0};
        dmem_wdata      = {16'b0, store_data[15:0]} << {addr[1], 4'b0000};
      end
      default: begin
        dmem_byteenable = 4'b1111;
        dmem_wdata      = store_data;
      end
    endcase
  end

  assign dmem_read  = ctl.mem_read && !read_sent;  // Held until not waited
  assign dmem_write = ctl.mem_write;
  assign mem_done   = (dmem_write && !dmem_wait) || (ctl.mem_read && dmem_rdata_valid);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      read_sent <= 1'b0;
    end else if (dmem_rdata_valid) begin
      read_sent <= 1'b0;
    end else if (dmem_read && !dmem_wait) begin
      read_sent <= 1'b1;
    end
  end

  // ======================================================================
  // Load side
  // ======================================================================

  assign rdata_lane = dmem_rdata >> lane_shift;

  always_ff @(posedge clk) begin
    if (ctl.mem_read && dmem_rdata_valid) begin
      case (size)
        MEM_BYTE: load_data <= f3[MEM_UNSIGNED_BIT] ? {24'b0, rdata_lane[7:0]}
                                                    : {{24{rdata_lane[7]}}, rdata_lane[7:0]};
        MEM_HALF: load_data <= f3[MEM_UNSIGNED_BIT] ? {16'b0, rdata_lane[15:0]}
                                                    : {{16{rdata_lane[15]}}, rdata_lane[15:0]};
        MEM_WORD: load_data <= rdata_lane;
        default:  load_data <= rdata_lane;
      endcase
    end
  end

endmodule

// ==== hw/register_file.sv ====
module register_file (
  input  logic           clk,
  input  logic [4:0]     rs1,
  input  logic [4:0]     rs2,
  input  logic [4:0]     rd,
  input  logic           we,
  input  cpu_pkg::word_t rd_data,
  output cpu_pkg::word_t rs1_data,
  output cpu_pkg::word_t rs2_data
);
  import cpu_pkg::*;

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== hw/alu.sv ====
module alu (
  input  cpu_pkg::word_t    a,
  input  cpu_pkg::word_t    b,
  input  cpu_pkg::alu_mode_e mode,
  output cpu_pkg::word_t    result,
  output logic              zero
);
  import cpu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (mode)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {31'b0, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;  // LUI
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);  // Branch decision input

endmodule

// ==== hw/control_unit.sv ====
module control_unit (
  input  logic                clk,
  input  logic                rst,
  input  rv_isa_pkg::opcode_e opcode,
  input  logic [2:0]          f3,
  input  logic                f7_bit5,
  input  logic                imem_wait,
  input  logic                imem_rdata_valid,
  input  logic                mem_done,
  ctrl_if.ctrl                ctl,
  output logic                imem_read,
  output logic                halted
);
  import cpu_pkg::*;
  import rv_isa_pkg::*;

  cpu_state_e state, state_next;
  logic fetch_sent;  // Fetch accepted, now waiting for read data
  logic pc_from_alu;

  // Shared funct3 map of OP and OP-IMM, only OP has a SUB form
  function automatic alu_mode_e arith_mode(input logic [2:0] fn, input logic alt,
                                           input logic has_sub);
    case (fn)
      3'b000:  return (alt && has_sub) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ======================================================================
  // Instruction decode, stable for the whole instruction
  // ======================================================================

  always_comb begin
    ctl.alu_a_sel = A_REG;
    ctl.alu_b_sel = B_IMM;
    ctl.alu_mode  = ALU_ADD;
    ctl.wb_sel    = WB_NONE;
    pc_from_alu   = 1'b0;
    case (opcode)
      OPC_LUI: begin
        ctl.alu_mode = ALU_PASS_B;
        ctl.wb_sel   = WB_ALU;
      end
      OPC_AUIPC: begin
        ctl.alu_a_sel = A_PC;
        ctl.wb_sel    = WB_ALU;
      end
      OPC_JAL: begin
        ctl.alu_a_sel = A_PC;
        ctl.wb_sel    = WB_LINK;
        pc_from_alu   = 1'b1;
      end
      OPC_JALR: begin
        ctl.wb_sel  = WB_LINK;
        pc_from_alu = 1'b1;
      end
      OPC_BRANCH: begin
        ctl.alu_b_sel = B_REG;
        pc_from_alu   = 1'b1;
        if (f3 == F3_BLT || f3 == F3_BGE) ctl.alu_mode = ALU_SLT;
        else if (f3 == F3_BLTU || f3 == F3_BGEU) ctl.alu_mode = ALU_SLTU;
        else ctl.alu_mode = ALU_SUB;  // Equality through a zero difference
      end
      OPC_LOAD: ctl.wb_sel = WB_MEM;
      OPC_OP_IMM: begin
        ctl.alu_mode = arith_mode(f3, f7_bit5, 1'b0);
        ctl.wb_sel   = WB_ALU;
      end
      OPC_OP: begin
        ctl.alu_b_sel = B_REG;
        ctl.alu_mode  = arith_mode(f3, f7_bit5, 1'b1);
        ctl.wb_sel    = WB_ALU;
      end
      default: ;  // Stores add rs1 and imm, unknown opcodes do nothing
    endcase
  end

  // ======================================================================
  // Sequencer
  // ======================================================================

  always_comb begin
    state_next = state;
    case (state)
      S_RESET:     state_next = S_FETCH;
      S_FETCH:     if (imem_rdata_valid) state_next = S_EXECUTE;
      S_EXECUTE: begin
        if (opcode == OPC_LOAD || opcode == OPC_STORE) state_next = S_MEMORY;
        else if (opcode == OPC_SYSTEM) state_next = S_HALT;
        else state_next = S_WRITEBACK;
      end
      S_MEMORY:    if (mem_done) state_next = S_WRITEBACK;
      S_WRITEBACK: state_next = S_FETCH;
      default:     state_next = S_HALT;  // HALT is final
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state      <= S_RESET;
      fetch_sent <= 1'b0;
    end else begin
      state <= state_next;
      if (ctl.ir_load) fetch_sent <= 1'b0;
      else if (imem_read && !imem_wait) fetch_sent <= 1'b1;
    end
  end

  assign imem_read       = (state == S_FETCH) && !fetch_sent;
  assign ctl.ir_load     = (state == S_FETCH) && imem_rdata_valid;
  assign ctl.mem_read    = (state == S_MEMORY) && (opcode == OPC_LOAD);
  assign ctl.mem_write   = (state == S_MEMORY) && (opcode == OPC_STORE);
  assign ctl.rd_write    = (state == S_WRITEBACK) && (ctl.wb_sel != WB_NONE);
  assign ctl.pc_load_alu = (state == S_WRITEBACK) && pc_from_alu;
  assign ctl.pc_advance  = (state == S_WRITEBACK) && !pc_from_alu;
  assign halted          = (state == S_HALT);

endmodule

// ==== hw/decoder.sv ====
module decoder (
  input  cpu_pkg::word_t     ir,
  output rv_isa_pkg::opcode_e opcode,
  output logic [4:0]         rd,
  output logic [4:0]         rs1,
  output logic [4:0]         rs2,
  output logic [2:0]         f3,
  output logic               f7_bit5,
  output cpu_pkg::word_t     imm
);
  import rv_isa_pkg::*;

  assign opcode  = opcode_e'(ir[6:0]);
  assign rd      = ir[11:7];
  assign f3      = ir[14:12];
  assign rs1     = ir[19:15];
  assign rs2     = ir[24:20];
  assign f7_bit5 = ir[30];  // Picks SUB and SRA/SRAI

  // Every format keeps its sign in ir[31]
  always_comb begin
    case (opcode)
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: begin
        imm = {{20{ir[31]}}, ir[31:20]};
      end
      OPC_STORE: begin
        imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      end
      OPC_BRANCH: begin
        imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      end
      OPC_LUI, OPC_AUIPC: begin
        imm = {ir[31:12], 12'b0};
      end
      OPC_JAL: begin
        imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      end
      default: begin
        imm = '0;  // R-type, SYSTEM and unknown opcodes carry no immediate
      end
    endcase
  end

endmodule

// ==== hw/ctrl_if.sv ====
interface ctrl_if;
  import cpu_pkg::*;

  alu_a_sel_e alu_a_sel;
  alu_b_sel_e alu_b_sel;
  alu_mode_e  alu_mode;
  wb_sel_e    wb_sel;
  logic       rd_write;
  logic       pc_load_alu;  // Jumps and branches, the top level picks the target
  logic       pc_advance;
  logic       ir_load;
  logic       mem_read;
  logic       mem_write;

  modport ctrl (
    output alu_a_sel, alu_b_sel, alu_mode, wb_sel, rd_write,
    output pc_load_alu, pc_advance, ir_load, mem_read, mem_write
  );

  modport dp (
    input alu_a_sel, alu_b_sel, alu_mode, wb_sel, rd_write,
    input pc_load_alu, pc_advance, ir_load, mem_read, mem_write
  );

endinterface

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // ======================================================================
  // RV32I encodings used by this core
  // ======================================================================

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Size lives in the two low bits of funct3, bit 2 selects zero extension
  localparam logic [2:0] MEM_BYTE = 3'b000;
  localparam logic [2:0] MEM_HALF = 3'b001;
  localparam logic [2:0] MEM_WORD = 3'b010;
  localparam int MEM_UNSIGNED_BIT = 2;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

  // ======================================================================
  // Datapath word and control encodings
  // ======================================================================

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  localparam word_t INSTR_BYTES = 32'd4;  // Fixed length, no compressed forms

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_mode_e;

  typedef enum logic {A_REG, A_PC} alu_a_sel_e;

  typedef enum logic {B_REG, B_IMM} alu_b_sel_e;

  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_LINK} wb_sel_e;  // LINK is PC+4

  typedef enum logic [2:0] {
    S_RESET,
    S_FETCH,
    S_EXECUTE,
    S_MEMORY,
    S_WRITEBACK,
    S_HALT
  } cpu_state_e;

endpackage
